// ==== Makefile ====
# Verilator build and run of the video core testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_video -f tb.f

run: compile
	./obj_dir/Vtb_video > sim.log 2>&1; cat sim.log
	@if grep -q '>>> FAIL' sim.log; then echo "simulation reported failure"; exit 1; fi
	@grep -q '>>> PASS' sim.log || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log

// ==== common/video_pkg.sv ====
`default_nettype none

package video_pkg;

    typedef logic [15:0] word_t;                // register data word
    typedef logic [7:0]  color_t;               // palette index
    typedef logic [10:0] hres_t;                // horizontal counter
    typedef logic [9:0]  vres_t;                // vertical counter

    typedef enum logic [1:0] {
        VISIBLE   = 2'd0,
        PRE_SYNC  = 2'd1,
        SYNC      = 2'd2,
        POST_SYNC = 2'd3
    } video_state_t;

    typedef enum logic [4:0] {
        XR_VID_CTRL     = 5'd0,
        XR_VID_LEFT     = 5'd6,
        XR_VID_RIGHT    = 5'd7,
        XR_SCANLINE     = 5'd8,
        XR_VID_HSIZE    = 5'd9,
        XR_VID_VSIZE    = 5'd10,
        XR_PA_GFX_CTRL  = 5'd16,
        XR_PA_DISP_ADDR = 5'd18,
        XR_PA_LINE_LEN  = 5'd19
    } reg_num_t;

    // tiny mode for simulation, visible area comes first on each line
    localparam int VISIBLE_WIDTH  = 16;
    localparam int H_FRONT_PORCH  = 2;
    localparam int H_SYNC_PULSE   = 3;
    localparam int H_BACK_PORCH   = 3;
    localparam int TOTAL_WIDTH    = VISIBLE_WIDTH + H_FRONT_PORCH + H_SYNC_PULSE + H_BACK_PORCH;

    localparam int VISIBLE_HEIGHT = 6;
    localparam int V_FRONT_PORCH  = 1;
    localparam int V_SYNC_PULSE   = 2;
    localparam int V_BACK_PORCH   = 1;
    localparam int TOTAL_HEIGHT   = VISIBLE_HEIGHT + V_FRONT_PORCH + V_SYNC_PULSE + V_BACK_PORCH;

    localparam logic H_SYNC_POLARITY = 1'b0;    // active low
    localparam logic V_SYNC_POLARITY = 1'b0;    // active low

    localparam color_t RESET_BORDER   = 8'h08;  // dark grey
    localparam word_t  RESET_LINE_LEN = 16'd8;

    localparam logic [1:0] INTR_VSYNC_BIT = 2'd3;

endpackage

`default_nettype wire

// ==== design/pixel_out.sv ====
`default_nettype none

module pixel_out (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire video_pkg::hres_t   h_count_i,
    input  wire logic               h_vis_i,
    input  wire logic               v_vis_i,
    input  wire logic               h_sync_i,
    input  wire logic               v_sync_i,
    input  wire video_pkg::color_t  border_color_i,
    input  wire video_pkg::hres_t   vid_left_i,
    input  wire video_pkg::hres_t   vid_right_i,
    input  wire logic               pa_blank_i,
    input  wire video_pkg::color_t  pa_colorbase_i,
    output logic                    hsync_o,
    output logic                    vsync_o,
    output logic                    dv_de_o,
    output video_pkg::color_t       color_index_o
);
    import video_pkg::*;

    logic       de;
    logic       in_window;
    color_t     color_next;

    assign de        = h_vis_i && v_vis_i;
    assign in_window = (h_count_i >= vid_left_i) && (h_count_i < vid_right_i);

    // border everywhere except the unblanked window
    assign color_next = (de && !pa_blank_i && in_window) ? pa_colorbase_i : border_color_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            hsync_o       <= ~H_SYNC_POLARITY;         // inactive level
            vsync_o       <= ~V_SYNC_POLARITY;
            dv_de_o       <= 1'b0;
            color_index_o <= '0;
        end else begin
            hsync_o       <= h_sync_i ? H_SYNC_POLARITY : ~H_SYNC_POLARITY;
            vsync_o       <= v_sync_i ? V_SYNC_POLARITY : ~V_SYNC_POLARITY;
            dv_de_o       <= de;
            color_index_o <= color_next;
        end
    end

    // sync pulse never overlaps active video
    a_no_de_in_hsync: assert property (@(posedge clk) disable iff (reset_i)
        dv_de_o |-> (hsync_o == ~H_SYNC_POLARITY) && (vsync_o == ~V_SYNC_POLARITY));

endmodule

`default_nettype wire

// ==== design/video_top.sv ====
`default_nettype none

module video_top (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire logic               reg_wr_i,
    input  wire video_pkg::reg_num_t reg_num_i,
    input  wire video_pkg::word_t   reg_data_i,
    output video_pkg::word_t        reg_data_o,
    input  wire logic [3:0]         intr_status_i,
    output logic [3:0]              intr_signal_o,
    output logic                    hsync_o,
    output logic                    vsync_o,
    output logic                    dv_de_o,
    output video_pkg::color_t       color_index_o
);
    import video_pkg::*;

    hres_t      h_count;
    vres_t      v_count;
    logic       h_vis;
    logic       v_vis;
    logic       h_sync;
    logic       v_sync;
    logic       last_visible_pixel;

    color_t     border_color;
    hres_t      vid_left;
    hres_t      vid_right;
    logic       pa_blank;
    color_t     pa_colorbase;

    video_timing u_timing (
        .clk                  (clk),
        .reset_i              (reset_i),
        .h_count_o            (h_count),
        .v_count_o            (v_count),
        .h_vis_o              (h_vis),
        .v_vis_o              (v_vis),
        .h_sync_o             (h_sync),
        .v_sync_o             (v_sync),
        .last_visible_pixel_o (last_visible_pixel)
    );

    video_regs u_regs (
        .clk                  (clk),
        .reset_i              (reset_i),
        .reg_wr_i             (reg_wr_i),
        .reg_num_i            (reg_num_i),
        .reg_data_i           (reg_data_i),
        .intr_status_i        (intr_status_i),
        .v_count_i            (v_count),
        .v_vis_i              (v_vis),
        .last_visible_pixel_i (last_visible_pixel),
        .reg_data_o           (reg_data_o),
        .intr_signal_o        (intr_signal_o),
        .border_color_o       (border_color),
        .vid_left_o           (vid_left),
        .vid_right_o          (vid_right),
        .pa_blank_o           (pa_blank),
        .pa_colorbase_o       (pa_colorbase)
    );

    pixel_out u_pixel (
        .clk                  (clk),
        .reset_i              (reset_i),
        .h_count_i            (h_count),
        .h_vis_i              (h_vis),
        .v_vis_i              (v_vis),
        .h_sync_i             (h_sync),
        .v_sync_i             (v_sync),
        .border_color_i       (border_color),
        .vid_left_i           (vid_left),
        .vid_right_i          (vid_right),
        .pa_blank_i           (pa_blank),
        .pa_colorbase_i       (pa_colorbase),
        .hsync_o              (hsync_o),
        .vsync_o              (vsync_o),
        .dv_de_o              (dv_de_o),
        .color_index_o        (color_index_o)
    );

endmodule

`default_nettype wire

// ==== dv/video_tests.svh ====
// called at a falling edge, each task also returns at one

task automatic reset_values();
    int       errors_before;
    word_t    rd;
    reg_num_t nums[12];
    word_t    exps[12];
    errors_before = error_count;
    if (dv_de !== 1'b0 || intr_signal !== 4'h0 || color_index !== 8'h00)
        report_problem("reset_values", "de, interrupt or colour output is not zero in reset");
    if (hsync !== ~H_SYNC_POLARITY || vsync !== ~V_SYNC_POLARITY)
        report_problem("reset_values", "a sync output is active in reset");
    @(negedge clk);
    if (dv_de !== 1'b1)
        report_problem("reset_values", "no display enable on the first pixel after reset");
    if (color_index !== RESET_BORDER)
        report_mismatch("reset_values", word_t'(RESET_BORDER), word_t'(color_index));
    nums = '{XR_VID_CTRL, XR_VID_LEFT, XR_VID_RIGHT, XR_VID_HSIZE, XR_VID_VSIZE,
             XR_PA_GFX_CTRL, XR_PA_DISP_ADDR, XR_PA_LINE_LEN,
             reg_num_t'(5'd1), reg_num_t'(5'd5), reg_num_t'(5'd17), reg_num_t'(5'd31)};
    exps = '{{RESET_BORDER, 4'h0, intr_status}, 16'h0, 16'h0, word_t'(VISIBLE_WIDTH),
             word_t'(VISIBLE_HEIGHT), 16'h0080, 16'h0, RESET_LINE_LEN,
             16'h0, 16'h0, 16'h0, 16'h0};       // gfx ctrl has only blank set
    for (int i = 0; i < 12; i++) begin
        read_reg(nums[i], rd);
        if (rd !== exps[i]) report_mismatch("reset_values", exps[i], rd);
    end
    end_of_test("reset_values", errors_before);
endtask

task automatic write_read_back();
    int       errors_before;
    word_t    data;
    word_t    rd;
    word_t    expected;
    reg_num_t nums[4];
    errors_before = error_count;
    nums = '{XR_VID_CTRL, XR_PA_GFX_CTRL, XR_PA_DISP_ADDR, XR_PA_LINE_LEN};
    intr_status = 4'b1011;                      // mixed status bits on the inputs
    for (int i = 0; i < 4; i++) begin
        data = next_random(16);
        write_reg(nums[i], data);
        read_reg(nums[i], rd);
        expected = data;
        if (nums[i] == XR_VID_CTRL) begin
            expected   = {data[15:8], 4'h0, intr_status};  // low bits are live status
            exp_border = data[15:8];
        end
        if (rd !== expected) report_mismatch("write_read_back", expected, rd);
    end
    end_of_test("write_read_back", errors_before);
endtask

task automatic frame_timing();
    int   errors_before;
    int   de_cycles;
    int   vsync_cycles;
    int   hsync_starts;
    int   run_len;
    logic hs_active;
    errors_before = error_count;
    de_cycles     = 0;
    vsync_cycles  = 0;
    hsync_starts  = 0;
    run_len       = 0;
    // start outside a pulse so none is cut at the front
    while (hsync !== ~H_SYNC_POLARITY) @(negedge clk);
    for (int i = 0; i < FRAME_CYCLES || run_len != 0; i++) begin
        hs_active = (hsync === H_SYNC_POLARITY);
        if (i < FRAME_CYCLES) begin
            if (dv_de === 1'b1) de_cycles++;
            if (vsync === V_SYNC_POLARITY) vsync_cycles++;
            if (hs_active && run_len == 0) hsync_starts++;
        end
        if (hs_active) begin
            run_len++;
        end else if (run_len != 0) begin
            if (run_len != H_SYNC_PULSE)
                report_mismatch("frame_timing", word_t'(H_SYNC_PULSE), word_t'(run_len));
            run_len = 0;
        end
        @(negedge clk);
    end
    if (de_cycles != VISIBLE_WIDTH * VISIBLE_HEIGHT)
        report_mismatch("frame_timing", word_t'(VISIBLE_WIDTH * VISIBLE_HEIGHT),
                        word_t'(de_cycles));
    if (hsync_starts != TOTAL_HEIGHT)
        report_mismatch("frame_timing", word_t'(TOTAL_HEIGHT), word_t'(hsync_starts));
    if (vsync_cycles != V_SYNC_PULSE * TOTAL_WIDTH)
        report_mismatch("frame_timing", word_t'(V_SYNC_PULSE * TOTAL_WIDTH),
                        word_t'(vsync_cycles));
    end_of_test("frame_timing", errors_before);
endtask

task automatic interrupt_pulses();
    int         errors_before;
    int         pulses;
    logic       prev;
    logic [3:0] others;
    errors_before = error_count;
    pulses        = 0;
    prev          = 1'b0;
    // a host write right after the frame pulse cannot meet the next one
    while (intr_signal[INTR_VSYNC_BIT] !== 1'b1) @(negedge clk);
    @(negedge clk);
    write_reg(XR_VID_CTRL, {exp_border, 4'h0, 4'b0101});
    if (intr_signal !== 4'b0101)
        report_mismatch("interrupt_pulses", 16'h0005, word_t'(intr_signal));
    @(negedge clk);
    if (intr_signal !== 4'b0000)
        report_mismatch("interrupt_pulses", 16'h0000, word_t'(intr_signal));
    for (int i = 0; i < 2 * FRAME_CYCLES; i++) begin
        others = intr_signal;
        others[INTR_VSYNC_BIT] = 1'b0;
        if (intr_signal[INTR_VSYNC_BIT] === 1'b1) begin
            pulses++;
            if (prev) report_problem("interrupt_pulses", "frame interrupt lasted over one cycle");
        end
        if (others !== 4'b0000)
            report_problem("interrupt_pulses", "an interrupt bit pulsed with no host write");
        prev = intr_signal[INTR_VSYNC_BIT];
        @(negedge clk);
    end
    if (pulses != 2) report_mismatch("interrupt_pulses", 16'd2, word_t'(pulses));
    end_of_test("interrupt_pulses", errors_before);
endtask

task automatic color_window();
    int     errors_before;
    int     col;
    color_t base;
    color_t expected;
    errors_before = error_count;
    base = 8'hb7;
    exp_border = 8'h21;
    write_reg(XR_VID_CTRL, {exp_border, 8'h00});
    write_reg(XR_VID_LEFT, 16'd4);
    write_reg(XR_VID_RIGHT, 16'd12);
    write_reg(XR_PA_GFX_CTRL, {base, 8'h00});
    for (int pass = 0; pass < 2; pass++) begin
        @(negedge clk);                         // let the output stage see the new fields
        while (dv_de !== 1'b0) @(negedge clk);  // column count starts at a line edge
        col = 0;
        for (int i = 0; i < FRAME_CYCLES; i++) begin
            expected = exp_border;
            if (dv_de === 1'b1) begin
                if (pass == 0 && col >= 4 && col < 12) expected = base;
                col++;
            end else begin
                col = 0;
            end
            if (color_index !== expected)
                report_mismatch("color_window", word_t'(expected), word_t'(color_index));
            @(negedge clk);
        end
        if (pass == 0) write_reg(XR_PA_GFX_CTRL, {base, 8'h80});  // blank on
    end
    end_of_test("color_window", errors_before);
endtask

task automatic scanline_read();
    int errors_before;
    int vis_seen;
    int sync_seen;
    errors_before = error_count;
    vis_seen      = 0;
    sync_seen     = 0;
    reg_num = XR_SCANLINE;
    @(negedge clk);
    for (int i = 0; i < FRAME_CYCLES; i++) begin
        if (dv_de === 1'b1) begin
            vis_seen++;
            if (reg_rdata[15] !== 1'b0)
                report_mismatch("scanline_read", 16'h0, word_t'(reg_rdata[15]));
            if (int'(reg_rdata[14:0]) >= VISIBLE_HEIGHT)
                report_problem("scanline_read", "line number past the visible height in display");
        end
        if (vsync === V_SYNC_POLARITY) begin
            sync_seen++;
            if (reg_rdata[15] !== 1'b1)
                report_mismatch("scanline_read", 16'h1, word_t'(reg_rdata[15]));
        end
        @(negedge clk);
    end
    if (vis_seen == 0 || sync_seen == 0)
        report_problem("scanline_read", "the frame showed no display or no vsync cycle");
    end_of_test("scanline_read", errors_before);
endtask

// ==== dv/tb_video.sv ====
`default_nettype none

module tb_video;
    timeunit 1ns;
    timeprecision 1ps;
    import video_pkg::*;

    localparam int FRAME_CYCLES   = TOTAL_WIDTH * TOTAL_HEIGHT;
    localparam int TIMEOUT_CYCLES = 8 * FRAME_CYCLES + 500;

    logic        clk = 1'b0;
    logic        reset;
    logic        reg_wr;
    reg_num_t    reg_num;
    word_t       reg_wdata;
    word_t       reg_rdata;
    logic [3:0]  intr_status;
    logic [3:0]  intr_signal;
    logic        hsync;
    logic        vsync;
    logic        dv_de;
    color_t      color_index;

    logic [15:0] lfsr;
    color_t      exp_border;                    // border colour last written
    int          error_count;
    int          test_count;
    int          cycle_count;

    video_top i_dut (
        .clk           (clk),
        .reset_i       (reset),
        .reg_wr_i      (reg_wr),
        .reg_num_i     (reg_num),
        .reg_data_i    (reg_wdata),
        .reg_data_o    (reg_rdata),
        .intr_status_i (intr_status),
        .intr_signal_o (intr_signal),
        .hsync_o       (hsync),
        .vsync_o       (vsync),
        .dv_de_o       (dv_de),
        .color_index_o (color_index)
    );

    // x^16 + x^14 + x^13 + x^11 + 1, one step per bit taken
    function automatic word_t next_random(input int nbits);
        word_t value;
        logic  fb;
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            fb    = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr  = {lfsr[14:0], fb};
            value = {value[14:0], fb};
        end
        return value;
    endfunction

    task automatic write_reg(input reg_num_t num, input word_t data);
        reg_wr    = 1'b1;
        reg_num   = num;
        reg_wdata = data;
        @(negedge clk);
        reg_wr    = 1'b0;
    endtask

    task automatic read_reg(input reg_num_t num, output word_t data);
        reg_num = num;
        @(negedge clk);
        data = reg_rdata;                       // registered one clock after the number
    endtask

    task automatic report_mismatch(input string name, input word_t expected,
                                   input word_t actual);
        $display("error %s: expected 0x%04h, actual 0x%04h", name, expected, actual);
        error_count++;
    endtask

    task automatic report_problem(input string name, input string what);
        $display("%s failed: %s", name, what);
        error_count++;
    endtask

    task automatic end_of_test(input string name, input int errors_before);
        test_count++;
        $display("test %s finished with %0d errors", name, error_count - errors_before);
    endtask

    `include "video_tests.svh"

    initial begin
        forever #2 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: tests still running after %0d cycles", cycle_count);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        lfsr        = 16'd19;
        exp_border  = RESET_BORDER;
        error_count = 0;
        test_count  = 0;
        reset       = 1'b1;
        reg_wr      = 1'b0;
        reg_num     = XR_VID_CTRL;
        reg_wdata   = '0;
        intr_status = 4'h0;
        repeat (4) @(negedge clk);
        reset = 1'b0;

        reset_values();
        write_read_back();
        frame_timing();
        interrupt_pulses();
        color_window();
        scanline_read();

        $display("tests run %0d, errors %0d", test_count, error_count);
        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== regs/video_regs.sv ====
`default_nettype none

module video_regs (
    input  wire logic                clk,
    input  wire logic                reset_i,
    input  wire logic                reg_wr_i,
    input  wire video_pkg::reg_num_t reg_num_i,
    input  wire video_pkg::word_t    reg_data_i,
    input  wire logic [3:0]          intr_status_i,
    input  wire video_pkg::vres_t    v_count_i,
    input  wire logic                v_vis_i,
    input  wire logic                last_visible_pixel_i,
    output video_pkg::word_t         reg_data_o,
    output logic [3:0]               intr_signal_o,
    output video_pkg::color_t        border_color_o,
    output video_pkg::hres_t         vid_left_o,
    output video_pkg::hres_t         vid_right_o,
    output logic                     pa_blank_o,
    output video_pkg::color_t        pa_colorbase_o
);
    import video_pkg::*;

    color_t     border_color;
    hres_t      vid_left;
    hres_t      vid_right;

    // playfield A config, only blank and colourbase drive the picture
    logic       pa_blank;
    color_t     pa_colorbase;
    logic       pa_bitmap;
    logic [1:0] pa_bpp;
    logic [1:0] pa_h_repeat;
    logic [1:0] pa_v_repeat;
    word_t      pa_disp_addr;
    word_t      pa_line_len;

    word_t      rd_data;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            intr_signal_o <= 4'b0;
            border_color  <= RESET_BORDER;
            vid_left      <= '0;
            vid_right     <= hres_t'(VISIBLE_WIDTH);   // full width window
            pa_blank      <= 1'b1;                     // playfield starts blanked
            pa_colorbase  <= '0;
            pa_bitmap     <= 1'b0;
            pa_bpp        <= 2'b0;
            pa_h_repeat   <= 2'b0;
            pa_v_repeat   <= 2'b0;
            pa_disp_addr  <= '0;
            pa_line_len   <= RESET_LINE_LEN;
        end else begin
            intr_signal_o <= 4'b0;                     // pulses last one cycle

            if (reg_wr_i) begin
                case (reg_num_i)
                    XR_VID_CTRL: begin
                        border_color  <= reg_data_i[15:8];
                        intr_signal_o <= reg_data_i[3:0];
                    end
                    XR_VID_LEFT: begin
                        vid_left      <= reg_data_i[10:0];
                    end
                    XR_VID_RIGHT: begin
                        vid_right     <= reg_data_i[10:0];
                    end
                    XR_PA_GFX_CTRL: begin
                        pa_colorbase  <= reg_data_i[15:8];
                        pa_blank      <= reg_data_i[7];
                        pa_bitmap     <= reg_data_i[6];
                        pa_bpp        <= reg_data_i[5:4];
                        pa_h_repeat   <= reg_data_i[3:2];
                        pa_v_repeat   <= reg_data_i[1:0];
                    end
                    XR_PA_DISP_ADDR: begin
                        pa_disp_addr  <= reg_data_i;
                    end
                    XR_PA_LINE_LEN: begin
                        pa_line_len   <= reg_data_i;
                    end
                    default: begin
                    end
                endcase
            end

            // end of visible frame, ORed on top of any host write
            if (last_visible_pixel_i) begin
                intr_signal_o[INTR_VSYNC_BIT] <= 1'b1;
            end
        end
    end

    always_comb begin
        case (reg_num_i)
            XR_VID_CTRL:     rd_data = {border_color, 4'b0, intr_status_i};
            XR_SCANLINE:     rd_data = {~v_vis_i, 5'b0, v_count_i};   // bit 15 set when off screen
            XR_VID_HSIZE:    rd_data = word_t'(VISIBLE_WIDTH);
            XR_VID_VSIZE:    rd_data = word_t'(VISIBLE_HEIGHT);
            XR_PA_GFX_CTRL:  rd_data = {pa_colorbase, pa_blank, pa_bitmap, pa_bpp,
                                        pa_h_repeat, pa_v_repeat};
            XR_PA_DISP_ADDR: rd_data = pa_disp_addr;
            XR_PA_LINE_LEN:  rd_data = pa_line_len;
            default:         rd_data = '0;           // left/right and unlisted
        endcase
    end

    always_ff @(posedge clk) begin
        reg_data_o <= rd_data;                       // one clock after reg_num_i
    end

    assign border_color_o = border_color;
    assign vid_left_o     = vid_left;
    assign vid_right_o    = vid_right;
    assign pa_blank_o     = pa_blank;
    assign pa_colorbase_o = pa_colorbase;

    a_intr_clear_after_reset: assert property (@(posedge clk)
        reset_i |=> intr_signal_o == 4'b0);

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+dv
common/video_pkg.sv
timing/video_timing.sv
regs/video_regs.sv
design/pixel_out.sv
design/video_top.sv
dv/tb_video.sv

// ==== timing/video_timing.sv ====
`default_nettype none

module video_timing (
    input  wire logic           clk,
    input  wire logic           reset_i,
    output video_pkg::hres_t    h_count_o,
    output video_pkg::vres_t    v_count_o,
    output logic                h_vis_o,
    output logic                v_vis_o,
    output logic                h_sync_o,
    output logic                v_sync_o,
    output logic                last_visible_pixel_o
);
    import video_pkg::*;

    video_state_t   h_state;
    video_state_t   h_state_next;
    video_state_t   v_state;
    video_state_t   v_state_next;

    hres_t          h_count;
    hres_t          h_count_next;
    hres_t          h_count_cmp;            // last count of current h state
    vres_t          v_count;
    vres_t          v_count_next;
    vres_t          v_count_cmp;            // last line of current v state

    logic           line_end;
    logic           frame_end;

    // both axes walk the same four states in order
    function automatic video_state_t state_after(input video_state_t s);
        case (s)
            VISIBLE:   state_after = PRE_SYNC;
            PRE_SYNC:  state_after = SYNC;
            SYNC:      state_after = POST_SYNC;
            default:   state_after = VISIBLE;
        endcase
    endfunction

    always_comb begin
        case (h_state)
            VISIBLE:   h_count_cmp = hres_t'(VISIBLE_WIDTH - 1);
            PRE_SYNC:  h_count_cmp = hres_t'(VISIBLE_WIDTH + H_FRONT_PORCH - 1);
            SYNC:      h_count_cmp = hres_t'(VISIBLE_WIDTH + H_FRONT_PORCH + H_SYNC_PULSE - 1);
            default:   h_count_cmp = hres_t'(TOTAL_WIDTH - 1);
        endcase
    end

    always_comb begin
        case (v_state)
            VISIBLE:   v_count_cmp = vres_t'(VISIBLE_HEIGHT - 1);
            PRE_SYNC:  v_count_cmp = vres_t'(VISIBLE_HEIGHT + V_FRONT_PORCH - 1);
            SYNC:      v_count_cmp = vres_t'(VISIBLE_HEIGHT + V_FRONT_PORCH + V_SYNC_PULSE - 1);
            default:   v_count_cmp = vres_t'(TOTAL_HEIGHT - 1);
        endcase
    end

    assign line_end  = (h_state == POST_SYNC) && (h_count == h_count_cmp);   // h wrap
    assign frame_end = line_end && (v_state == POST_SYNC) && (v_count == v_count_cmp);

    assign h_state_next = (h_count == h_count_cmp) ? state_after(h_state) : h_state;
    assign v_state_next = (line_end && v_count == v_count_cmp) ? state_after(v_state) : v_state;

    assign h_count_next = line_end ? '0 : h_count + 1'b1;

    always_comb begin
        v_count_next = v_count;
        if (frame_end) begin
            v_count_next = '0;
        end else if (line_end) begin
            v_count_next = v_count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_state <= VISIBLE;
            v_state <= VISIBLE;
            h_count <= '0;
            v_count <= '0;
        end else begin
            h_state <= h_state_next;
            v_state <= v_state_next;
            h_count <= h_count_next;
            v_count <= v_count_next;
        end
    end

    assign h_count_o = h_count;
    assign v_count_o = v_count;
    assign h_vis_o   = (h_state == VISIBLE);
    assign v_vis_o   = (v_state == VISIBLE);
    assign h_sync_o  = (h_state == SYNC);
    assign v_sync_o  = (v_state == SYNC);

    // wrap of the final visible line
    assign last_visible_pixel_o = line_end && (v_state == VISIBLE) && (v_count == v_count_cmp);

    a_h_count_range: assert property (@(posedge clk) disable iff (reset_i)
        h_count < hres_t'(TOTAL_WIDTH));

    a_v_count_range: assert property (@(posedge clk) disable iff (reset_i)
        v_count < vres_t'(TOTAL_HEIGHT));

endmodule

`default_nettype wire
